// File: reg_table.f
+incdir+dv
common/reg_table_pkg.sv
design/table_store/entry_match.sv
design/table_store/table_store.sv
design/operand_lookup.sv
design/reg_table.sv
dv/tb_reg_table.sv

// File: Bender.yml
package:
  name: reg_table

sources:
  - common/reg_table_pkg.sv
  - design/table_store/entry_match.sv
  - design/table_store/table_store.sv
  - design/operand_lookup.sv
  - design/reg_table.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_reg_table.sv

// File: dv/reg_table_model.svh
/*
 * Behavioral scoreboard model and LFSR source for the register table testbench.
 * Included inside the testbench module, after its sizing localparams.
 */

`ifndef REG_TABLE_MODEL_SVH
`define REG_TABLE_MODEL_SVH

// Model entries
logic [NumTags-1:0]     m_valid;
logic [RegIdxWidth-1:0] m_dst  [NumTags];
logic [SwWidth-1:0]     m_sw   [NumTags];
logic [TagWidth-1:0]    m_prod [NumTags];

// Stimulus source state
logic [15:0] lfsr_q;

// Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per bit taken
function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned r;
    r = 0;
    for (int unsigned i = 0; i < n; i++) begin
        lfsr_q = lfsr_step(lfsr_q);
        r = (r << 1) | lfsr_q[0];
    end
    return r;
endfunction

function automatic void clear_table();
    m_valid = '0;
    for (int e = 0; e < NumTags; e++) begin
        m_dst[e]  = '0;
        m_sw[e]   = '0;
        m_prod[e] = '0;
    end
endfunction

// Lowest valid entry holding this destination
// Returns -1 when nothing matches
function automatic int find_pending(input logic [RegIdxWidth-1:0] r,
                                    input logic [SwWidth-1:0] sw);
    int idx;
    idx = -1;
    for (int e = 0; e < NumTags; e++) begin
        if (idx < 0 && m_valid[e] && m_dst[e] == r && m_sw[e] == sw) begin
            idx = e;
        end
    end
    return idx;
endfunction

function automatic logic tag_is_held(input logic [TagWidth-1:0] tag);
    logic held;
    held = 1'b0;
    for (int e = 0; e < NumTags; e++) begin
        if (m_valid[e] && m_prod[e] == tag) begin
            held = 1'b1;
        end
    end
    return held;
endfunction

function automatic logic has_space();
    return !(&m_valid);
endfunction

function automatic logic nothing_pending();
    return m_valid == '0;
endfunction

// One clock edge with lookups on old state, then retire and insert
function automatic void apply_edge(input logic ins, input logic [TagWidth-1:0] tag,
                                   input logic [SwWidth-1:0] sw,
                                   input logic [RegIdxWidth-1:0] dst,
                                   input logic euv, input logic [TagWidth-1:0] eut);
    int   hit;
    int   free_e;
    logic accepted;
    hit      = find_pending(dst, sw);
    accepted = ins && has_space();
    free_e   = -1;
    for (int e = 0; e < NumTags; e++) begin
        if (free_e < 0 && !m_valid[e]) begin
            free_e = e;
        end
    end
    if (euv) begin
        for (int e = 0; e < NumTags; e++) begin
            if (m_valid[e] && m_prod[e] == eut) begin
                m_valid[e] = 1'b0;
            end
        end
    end
    if (accepted) begin
        if (hit >= 0) begin
            // Pending destination keeps its slot and takes the new producer
            m_valid[hit] = 1'b1;
            m_prod[hit]  = tag;
        end else begin
            m_valid[free_e] = 1'b1;
            m_dst[free_e]   = dst;
            m_sw[free_e]    = sw;
            m_prod[free_e]  = tag;
        end
    end
endfunction

`endif

// File: dv/tb_reg_table.sv
/*
 * Random-stimulus testbench for the register scoreboard top level.
 * Compares every output against the included model just before each rising edge.
 */

`timescale 1ns/10ps

module tb_reg_table;

    localparam int unsigned NumTags        = reg_table_pkg::DEFAULT_NUM_TAGS;
    localparam int unsigned WarpWidth      = reg_table_pkg::DEFAULT_WARP_WIDTH;
    localparam int unsigned RegIdxWidth    = reg_table_pkg::DEFAULT_REG_IDX_WIDTH;
    localparam int unsigned Ops            = reg_table_pkg::DEFAULT_OPERANDS_PER_INST;
    localparam int unsigned TagWidth       = reg_table_pkg::idx_width(NumTags);
    localparam int unsigned SwWidth        = reg_table_pkg::idx_width(WarpWidth);

    localparam int unsigned HalfPeriod     = 20;
    localparam int unsigned ResetCycles    = 10;
    localparam int unsigned NumCycles      = 2000;
    localparam int unsigned PhaseLen       = 100;
    localparam int unsigned WatchdogCycles = ResetCycles + NumCycles + 90;

    logic                             clk_i;
    logic                             rst_n_i;
    logic                             insert_i;
    logic [TagWidth-1:0]              tag_i;
    logic [SwWidth-1:0]               subwarp_id_i;
    logic [RegIdxWidth-1:0]           dst_reg_i;
    logic [Ops-1:0][RegIdxWidth-1:0]  operands_reg_i;
    logic                             space_available_o;
    logic                             all_dst_written_o;
    logic [Ops-1:0]                   operands_ready_o;
    logic [Ops-1:0][TagWidth-1:0]     operands_tag_o;
    logic                             eu_valid_i;
    logic [TagWidth-1:0]              eu_tag_i;

    int error_count = 0;

    `include "reg_table_model.svh"

    reg_table uut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .insert_i          (insert_i),
        .tag_i             (tag_i),
        .subwarp_id_i      (subwarp_id_i),
        .dst_reg_i         (dst_reg_i),
        .operands_reg_i    (operands_reg_i),
        .space_available_o (space_available_o),
        .all_dst_written_o (all_dst_written_o),
        .operands_ready_o  (operands_ready_o),
        .operands_tag_o    (operands_tag_o),
        .eu_valid_i        (eu_valid_i),
        .eu_tag_i          (eu_tag_i)
    );

    always #HalfPeriod clk_i = ~clk_i;

    // ####################################################################
    // Checking
    // ####################################################################

    task automatic report_mismatch(input string what);
        error_count++;
        $display("mismatch at %0t: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_outputs();
        int                  hit;
        logic [TagWidth-1:0] exp_tag;
        logic                exp_ready;
        assert (space_available_o === has_space())
            else report_mismatch($sformatf("space_available_o is %b", space_available_o));
        assert (all_dst_written_o === nothing_pending())
            else report_mismatch($sformatf("all_dst_written_o is %b", all_dst_written_o));
        for (int op = 0; op < Ops; op++) begin
            hit = find_pending(operands_reg_i[op], subwarp_id_i);
            if (hit < 0) begin
                // Nothing pending for this register
                exp_tag   = '0;
                exp_ready = 1'b1;
            end else begin
                // Waits unless its producer retires this cycle
                exp_tag   = m_prod[hit];
                exp_ready = eu_valid_i && (eu_tag_i == exp_tag);
            end
            assert (operands_tag_o[op] === exp_tag)
                else report_mismatch($sformatf("operand %0d tag is %0d, expected %0d",
                    op, operands_tag_o[op], exp_tag));
            assert (operands_ready_o[op] === exp_ready)
                else report_mismatch($sformatf("operand %0d ready is %b, expected %b",
                    op, operands_ready_o[op], exp_ready));
        end
    endtask

    // ####################################################################
    // Stimulus
    // ####################################################################

    // Fill phase inserts often
    // Drain phase mostly retires
    task automatic drive_random(input logic drain);
        logic [TagWidth-1:0] t;
        int                  n;
        if (drain) begin
            insert_i = (rand_bits(3) == 0);
        end else begin
            insert_i = (rand_bits(2) != 0);
        end
        dst_reg_i    = RegIdxWidth'(rand_bits(RegIdxWidth));
        subwarp_id_i = SwWidth'(rand_bits(SwWidth));
        // Walk to a tag the model does not hold
        // When full every tag is held but the insert gets dropped
        t = TagWidth'(rand_bits(TagWidth));
        n = 0;
        while (tag_is_held(t) && n < NumTags) begin
            t = t + 1'b1;
            n++;
        end
        tag_i = t;
        for (int op = 0; op < Ops; op++) begin
            operands_reg_i[op] = RegIdxWidth'(rand_bits(RegIdxWidth));
        end
        eu_valid_i = drain ? (rand_bits(2) != 0) : (rand_bits(1) != 0);
        // Retire tag is mostly a held one and now and then an absent one
        t = TagWidth'(rand_bits(TagWidth));
        if (rand_bits(2) != 0) begin
            n = 0;
            while (!tag_is_held(t) && n < NumTags) begin
                t = t + 1'b1;
                n++;
            end
        end
        eu_tag_i = t;
    endtask

    // ####################################################################
    // Main sequence and watchdog
    // ####################################################################

    initial begin
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        insert_i       = 1'b0;
        tag_i          = '0;
        subwarp_id_i   = '0;
        dst_reg_i      = '0;
        operands_reg_i = '0;
        eu_valid_i     = 1'b0;
        eu_tag_i       = '0;
        lfsr_q         = 16'd63;
        clear_table();
        repeat (ResetCycles) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        // First pass sees the empty table right after reset
        for (int cyc = 0; cyc < NumCycles; cyc++) begin
            drive_random(((cyc / PhaseLen) % 2) == 1);
            #(HalfPeriod - 2);
            check_outputs();
            @(posedge clk_i);
            apply_edge(insert_i, tag_i, subwarp_id_i, dst_reg_i, eu_valid_i, eu_tag_i);
            @(negedge clk_i);
        end
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * 2 * HalfPeriod);
        $display("watchdog expired: the test did not finish in time");
        $display("TB FAILED");
        $fatal(1, "hang detected");
    end

endmodule

// File: design/reg_table.sv
/*
 * Register scoreboard top level: maps pending destinations to producer tags.
 * Sets sizing and wires the store, the matchers and the operand lookup.
 */

`timescale 1ns/10ps

module reg_table #(
    parameter int unsigned NumTags         = reg_table_pkg::DEFAULT_NUM_TAGS,
    parameter int unsigned WarpWidth       = reg_table_pkg::DEFAULT_WARP_WIDTH,
    parameter int unsigned RegIdxWidth     = reg_table_pkg::DEFAULT_REG_IDX_WIDTH,
    parameter int unsigned OperandsPerInst = reg_table_pkg::DEFAULT_OPERANDS_PER_INST
) (
    input  logic                                                              clk_i,
    input  logic                                                              rst_n_i,

    // Decoder side
    input  logic                                                              insert_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]                      tag_i,
    input  logic [reg_table_pkg::idx_width(WarpWidth)-1:0]                    subwarp_id_i,
    input  logic [RegIdxWidth-1:0]                                            dst_reg_i,
    input  logic [OperandsPerInst-1:0][RegIdxWidth-1:0]                       operands_reg_i,
    output logic                                                              space_available_o,

    // Fetcher side sees when no writes are pending
    output logic                                                              all_dst_written_o,

    // Wait buffer side
    output logic [OperandsPerInst-1:0]                                        operands_ready_o,
    output logic [OperandsPerInst-1:0][reg_table_pkg::idx_width(NumTags)-1:0] operands_tag_o,

    // Execution unit retire
    input  logic                                                              eu_valid_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]                      eu_tag_i
);

    localparam int unsigned IdxWidth = reg_table_pkg::idx_width(NumTags);
    localparam int unsigned TagWidth = reg_table_pkg::idx_width(NumTags);
    localparam int unsigned SwWidth  = reg_table_pkg::idx_width(WarpWidth);

    // Entry arrays
    logic [NumTags-1:0]                  tbl_valid;
    logic [NumTags-1:0][RegIdxWidth-1:0] tbl_dst;
    logic [NumTags-1:0][SwWidth-1:0]     tbl_subwarp;
    logic [NumTags-1:0][TagWidth-1:0]    tbl_producer;

    // Insert destination match
    logic                reuse_found;
    logic [IdxWidth-1:0] reuse_index;

    // Operand matches
    logic [OperandsPerInst-1:0]               op_found;
    logic [OperandsPerInst-1:0][IdxWidth-1:0] op_index;

    table_store #(
        .NumTags     (NumTags),
        .RegIdxWidth (RegIdxWidth),
        .WarpWidth   (WarpWidth)
    ) u_store (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .insert_i          (insert_i),
        .tag_i             (tag_i),
        .subwarp_id_i      (subwarp_id_i),
        .dst_reg_i         (dst_reg_i),
        .reuse_found_i     (reuse_found),
        .reuse_index_i     (reuse_index),
        .eu_valid_i        (eu_valid_i),
        .eu_tag_i          (eu_tag_i),
        .valid_o           (tbl_valid),
        .dst_o             (tbl_dst),
        .subwarp_o         (tbl_subwarp),
        .producer_o        (tbl_producer),
        .space_available_o (space_available_o),
        .all_dst_written_o (all_dst_written_o)
    );

    // Is the insert destination already pending
    entry_match #(
        .NumTags     (NumTags),
        .RegIdxWidth (RegIdxWidth),
        .WarpWidth   (WarpWidth)
    ) u_insert_match (
        .valid_i       (tbl_valid),
        .dst_i         (tbl_dst),
        .subwarp_i     (tbl_subwarp),
        .key_reg_i     (dst_reg_i),
        .key_subwarp_i (subwarp_id_i),
        .found_o       (reuse_found),
        .index_o       (reuse_index)
    );

    // One search per source operand under the insert subwarp
    for (genvar op = 0; op < OperandsPerInst; op++) begin : gen_op_match
        entry_match #(
            .NumTags     (NumTags),
            .RegIdxWidth (RegIdxWidth),
            .WarpWidth   (WarpWidth)
        ) u_op_match (
            .valid_i       (tbl_valid),
            .dst_i         (tbl_dst),
            .subwarp_i     (tbl_subwarp),
            .key_reg_i     (operands_reg_i[op]),
            .key_subwarp_i (subwarp_id_i),
            .found_o       (op_found[op]),
            .index_o       (op_index[op])
        );
    end

    operand_lookup #(
        .NumTags         (NumTags),
        .OperandsPerInst (OperandsPerInst)
    ) u_lookup (
        .producer_i       (tbl_producer),
        .found_i          (op_found),
        .index_i          (op_index),
        .eu_valid_i       (eu_valid_i),
        .eu_tag_i         (eu_tag_i),
        .operands_ready_o (operands_ready_o),
        .operands_tag_o   (operands_tag_o)
    );

endmodule

// File: design/operand_lookup.sv
/*
 * Operand readiness and producer tag from the per-operand match results.
 * Purely combinational; a tag retiring this cycle counts as ready.
 */

`timescale 1ns/10ps

module operand_lookup #(
    parameter int unsigned NumTags         = 4,
    parameter int unsigned OperandsPerInst = 2
) (
    // Producer array from the store
    input  logic [NumTags-1:0][reg_table_pkg::idx_width(NumTags)-1:0]         producer_i,

    // Matcher results, one per operand
    input  logic [OperandsPerInst-1:0]                                        found_i,
    input  logic [OperandsPerInst-1:0][reg_table_pkg::idx_width(NumTags)-1:0] index_i,

    // Retire bypass
    input  logic                                                              eu_valid_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]                      eu_tag_i,

    // Toward the wait buffer
    output logic [OperandsPerInst-1:0]                                        operands_ready_o,
    output logic [OperandsPerInst-1:0][reg_table_pkg::idx_width(NumTags)-1:0] operands_tag_o
);

    localparam int unsigned TagWidth = reg_table_pkg::idx_width(NumTags);

    // ####################################################################
    // Tag select and bypass
    // ####################################################################

    // Producer tag of the matched entry, per operand
    logic [OperandsPerInst-1:0][TagWidth-1:0] matched_tag;

    always_comb begin
        for (int op = 0; op < OperandsPerInst; op++) begin
            matched_tag[op] = producer_i[index_i[op]];
        end
    end

    always_comb begin
        for (int op = 0; op < OperandsPerInst; op++) begin
            if (found_i[op]) begin
                // Still pending unless its producer retires right now
                operands_tag_o[op]   = matched_tag[op];
                operands_ready_o[op] = eu_valid_i && (eu_tag_i == matched_tag[op]);
            end else begin
                // Nothing pending so the value is already in the register file
                operands_tag_o[op]   = '0;
                operands_ready_o[op] = 1'b1;
            end
        end
    end

endmodule

// File: design/table_store/table_store.sv
/*
 * Registered scoreboard entries with insert, reuse and retire-clear.
 * Next state is sampled at each edge; occupancy levels come from registered state.
 */

`timescale 1ns/10ps

module table_store #(
    parameter int unsigned NumTags     = 4,
    parameter int unsigned RegIdxWidth = 2,
    parameter int unsigned WarpWidth   = 2
) (
    input  logic                                                       clk_i,
    input  logic                                                       rst_n_i,

    // Insert from the decoder
    input  logic                                                       insert_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]               tag_i,
    input  logic [reg_table_pkg::idx_width(WarpWidth)-1:0]             subwarp_id_i,
    input  logic [RegIdxWidth-1:0]                                     dst_reg_i,

    // Existing-entry match for the insert destination
    input  logic                                                       reuse_found_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]               reuse_index_i,

    // Retire from the execution unit
    input  logic                                                       eu_valid_i,
    input  logic [reg_table_pkg::idx_width(NumTags)-1:0]               eu_tag_i,

    // Entry arrays
    output logic [NumTags-1:0]                                         valid_o,
    output logic [NumTags-1:0][RegIdxWidth-1:0]                        dst_o,
    output logic [NumTags-1:0][reg_table_pkg::idx_width(WarpWidth)-1:0] subwarp_o,
    output logic [NumTags-1:0][reg_table_pkg::idx_width(NumTags)-1:0]  producer_o,

    // Occupancy levels
    output logic                                                       space_available_o,
    output logic                                                       all_dst_written_o
);

    localparam int unsigned IdxWidth = reg_table_pkg::idx_width(NumTags);
    localparam int unsigned TagWidth = reg_table_pkg::idx_width(NumTags);
    localparam int unsigned SwWidth  = reg_table_pkg::idx_width(WarpWidth);

    // ####################################################################
    // State
    // ####################################################################

    logic [NumTags-1:0]                  valid_q, valid_d;
    logic [NumTags-1:0][RegIdxWidth-1:0] dst_q, dst_d;
    logic [NumTags-1:0][SwWidth-1:0]     subwarp_q, subwarp_d;
    logic [NumTags-1:0][TagWidth-1:0]    producer_q, producer_d;

    // Accepted insert and the first free slot
    logic                insert_en;
    logic [IdxWidth-1:0] free_idx;

    // Full table blocks inserts; empty table means nothing pending
    assign space_available_o = ~&valid_q;
    assign all_dst_written_o = ~|valid_q;

    assign insert_en = insert_i && space_available_o;

    // Lowest invalid entry from registered state
    always_comb begin
        free_idx = '0;
        for (int e = NumTags - 1; e >= 0; e--) begin
            if (!valid_q[e]) begin
                free_idx = e[IdxWidth-1:0];
            end
        end
    end

    // ####################################################################
    // Next state
    // ####################################################################

    always_comb begin
        valid_d    = valid_q;
        dst_d      = dst_q;
        subwarp_d  = subwarp_q;
        producer_d = producer_q;

        // Retire first and drop every entry produced by this tag
        if (eu_valid_i) begin
            for (int e = 0; e < NumTags; e++) begin
                if (valid_q[e] && (producer_q[e] == eu_tag_i)) begin
                    valid_d[e] = 1'b0;
                end
            end
        end

        if (insert_en) begin
            if (reuse_found_i) begin
                // Pending dst keeps its entry alive even if just retired
                valid_d[reuse_index_i]    = 1'b1;
                producer_d[reuse_index_i] = tag_i;
            end else begin
                // Fresh entry
                valid_d[free_idx]    = 1'b1;
                dst_d[free_idx]      = dst_reg_i;
                subwarp_d[free_idx]  = subwarp_id_i;
                producer_d[free_idx] = tag_i;
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        dst_q      <= dst_d;
        subwarp_q  <= subwarp_d;
        producer_q <= producer_d;
    end

    assign valid_o    = valid_q;
    assign dst_o      = dst_q;
    assign subwarp_o  = subwarp_q;
    assign producer_o = producer_q;

    // ####################################################################
    // Checks
    // ####################################################################

    for (genvar i = 0; i < NumTags; i++) begin : gen_pair_chk
        for (genvar j = i + 1; j < NumTags; j++) begin : gen_pair_chk_inner
            // Reuse path must prevent duplicate destinations
            a_unique_dst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !(valid_q[i] && valid_q[j])
                || (dst_q[i] != dst_q[j]) || (subwarp_q[i] != subwarp_q[j]))
                else $error("entries %0d and %0d hold the same destination", i, j);

            // Tags stay unique as long as the decoder obeys its rule
            a_unique_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !(valid_q[i] && valid_q[j]) || (producer_q[i] != producer_q[j]))
                else $error("entries %0d and %0d hold the same tag", i, j);
        end
    end

    // Retired tag leaves the table unless re-inserted in the same cycle
    for (genvar e = 0; e < NumTags; e++) begin : gen_retire_chk
        a_retire_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (eu_valid_i && !(insert_en && (tag_i == eu_tag_i)))
            |=> !(valid_q[e] && (producer_q[e] == $past(eu_tag_i))))
            else $error("entry %0d still holds retired tag", e);
    end

endmodule

// File: design/table_store/entry_match.sv
/*
 * Priority search over the scoreboard entries for a destination and subwarp.
 * Returns the lowest valid entry that matches; used for reuse and operand lookup.
 */

`timescale 1ns/10ps

module entry_match #(
    parameter int unsigned NumTags     = 4,
    parameter int unsigned RegIdxWidth = 2,
    parameter int unsigned WarpWidth   = 2
) (
    // Entry arrays from the store
    input  logic [NumTags-1:0]                                             valid_i,
    input  logic [NumTags-1:0][RegIdxWidth-1:0]                            dst_i,
    input  logic [NumTags-1:0][reg_table_pkg::idx_width(WarpWidth)-1:0]    subwarp_i,

    // Search key
    input  logic [RegIdxWidth-1:0]                                         key_reg_i,
    input  logic [reg_table_pkg::idx_width(WarpWidth)-1:0]                 key_subwarp_i,

    // Result
    output logic                                                           found_o,
    output logic [reg_table_pkg::idx_width(NumTags)-1:0]                   index_o
);

    localparam int unsigned IdxWidth = reg_table_pkg::idx_width(NumTags);

    // Per-entry hit vector
    logic [NumTags-1:0] hit;

    always_comb begin
        for (int e = 0; e < NumTags; e++) begin
            hit[e] = valid_i[e] && (dst_i[e] == key_reg_i)
                && (subwarp_i[e] == key_subwarp_i);
        end
    end

    // Scan downward so the lowest hit is written last and wins
    always_comb begin
        found_o = 1'b0;
        index_o = '0;
        for (int e = NumTags - 1; e >= 0; e--) begin
            if (hit[e]) begin
                found_o = 1'b1;
                index_o = e[IdxWidth-1:0];
            end
        end
    end

endmodule

// File: common/reg_table_pkg.sv
/*
 * Shared defaults and width helper for the register scoreboard.
 * Modules reach these by scoped name; the top level passes values down.
 */

package reg_table_pkg;

    // ####################################################################
    // Default sizing
    // ####################################################################

    // One table entry per tag, so entries and tags share this count
    localparam int unsigned DEFAULT_NUM_TAGS = 4;

    // Subwarps sharing one table
    localparam int unsigned DEFAULT_WARP_WIDTH = 2;

    // Bits in an architectural register index
    localparam int unsigned DEFAULT_REG_IDX_WIDTH = 2;

    // Source operands looked up each cycle
    localparam int unsigned DEFAULT_OPERANDS_PER_INST = 2;

    // ####################################################################
    // Width helper
    // ####################################################################

    // Bits needed to index count items
    // Never below one bit, so a count of 1 still yields a usable field
    function automatic int unsigned idx_width(input int unsigned count);
        int unsigned width;
        if (count > 1) begin
            width = $clog2(count);
        end else begin
            width = 1;
        end
        return width;
    endfunction

endpackage
